// File: sources.f
+incdir+include
src/isa_pkg.sv
src/ahb_pkg.sv
src/pipeline_1_fe.sv
src/pipeline_2_ex.sv
src/rf_controller.sv
src/core_top.sv
verif/tb_clock_gen.sv
verif/core_assertions.sv
verif/core_tb.sv

// File: verif/core_vectors.txt
// Columns: kind program word_or_rd check_or_value fault
// Kind 1 is an instruction word with its checksum, fault 1 corrupts its delivery
// Kind 2 is an expected retire record with rd and value, last column unused
1 0 00500093 00 0
1 0 ffd08113 17 0
1 0 002081b3 15 0
1 0 40118233 5c 0
1 0 123452b7 18 0
1 0 0f02c313 14 0
1 0 004363b3 12 0
1 0 0ff3f013 44 0
1 1 0f006093 01 0
1 1 03c0f113 0d 0
1 1 0020c1b3 5b 0
1 1 0011f233 4d 0
1 1 00120293 4e 1
1 1 00700313 13 0
2 0 01 00000005 0
2 0 02 00000002 0
2 0 03 00000007 0
2 0 04 00000002 0
2 0 05 12345000 0
2 0 06 123450f0 0
2 0 07 123450f2 0
2 0 00 00000000 0
2 1 01 000000f0 0
2 1 02 00000030 0
2 1 03 000000c0 0
2 1 04 000000c0 0

// File: verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int          CLK_PERIOD  = 4;
    localparam int          VEC_ENTRIES = 200;   // Five entries per record
    localparam int          MEM_WORDS   = 64;
    localparam int          MAX_EXP     = 16;
    localparam int          DRAIN       = 10;    // Quiet cycles watched after each run
    localparam logic [31:0] BOOT_A      = 32'h0000_0000;
    localparam logic [31:0] BOOT_B      = 32'h0000_0040;

    logic             s_clk;
    logic             rst_n;
    isa_pkg::word_t   s_boot_add;
    isa_pkg::word_t   s_hrdata;
    logic             s_hready;
    logic             s_hresp;
    ahb_pkg::chk_t    s_hrchecksum;
    isa_pkg::word_t   s_haddr;
    ahb_pkg::htrans_e s_htrans;
    logic             s_fetch_err;
    logic             s_ret_valid;
    isa_pkg::rf_add_t s_ret_rd;
    isa_pkg::word_t   s_ret_val;

    logic [31:0] vec [VEC_ENTRIES];
    logic [31:0] mem_word [MEM_WORDS];
    logic [6:0]  mem_chk [MEM_WORDS];
    int          mem_fault [MEM_WORDS];  // Non-zero marks a corrupted word
    logic [31:0] exp_rd [2][MAX_EXP];
    logic [31:0] exp_val [2][MAX_EXP];
    int          exp_cnt [2];
    int          word_cnt [2];
    int          seed;
    int          errors;
    int          prog;
    int          ret_idx;
    int          base_word;
    int          end_word;
    bit          hresp_run;              // Deliver marked words as error responses
    bit          err_seen;
    bit          dp_pending;
    bit          loaded = 1'b0;
    logic [31:0] dp_addr;
    logic [31:0] next_addr;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clock_gen_inst (.s_clk_o(s_clk));

    core_top core_top_inst (
        .s_clk_i          (s_clk),
        .rst_n_i          (rst_n),
        .s_boot_add_i     (s_boot_add),
        .s_i_hrdata_i     (s_hrdata),
        .s_i_hready_i     (s_hready),
        .s_i_hresp_i      (s_hresp),
        .s_i_hrchecksum_i (s_hrchecksum),
        .s_i_haddr_o      (s_haddr),
        .s_i_htrans_o     (s_htrans),
        .s_fetch_err_o    (s_fetch_err),
        .s_ret_valid_o    (s_ret_valid),
        .s_ret_rd_o       (s_ret_rd),
        .s_ret_val_o      (s_ret_val)
    );

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] boot_addr(input int p);
        return (p == 0) ? BOOT_A : BOOT_B;
    endfunction

    function automatic bit in_program(input logic [31:0] addr);
        return ((addr >> 2) >= base_word) && ((addr >> 2) < end_word);
    endfunction

    task automatic load_vectors();
        int          r;
        int          p;
        logic [31:0] widx;
        for (r = 0; r < VEC_ENTRIES; r++) vec[r] = '0;
        for (r = 0; r < MEM_WORDS; r++) begin
            mem_word[r]  = '0;
            mem_chk[r]   = '0;
            mem_fault[r] = 0;
        end
        $readmemh("verif/core_vectors.txt", vec);
        for (r = 0; (r + 4 < VEC_ENTRIES) && (vec[r] != 0); r += 5) begin
            p = vec[r+1];
            if (vec[r] == 1) begin           // Instruction words are placed from the boot address
                widx            = (boot_addr(p) >> 2) + word_cnt[p];
                mem_word[widx]  = vec[r+2];
                mem_chk[widx]   = vec[r+3][6:0];
                mem_fault[widx] = vec[r+4];
                word_cnt[p]++;
            end else begin
                exp_rd[p][exp_cnt[p]]  = vec[r+2];
                exp_val[p][exp_cnt[p]] = vec[r+3];
                exp_cnt[p]++;
            end
        end
        if ((exp_cnt[0] == 0) || (exp_cnt[1] == 0)) begin
            $display("The vector file gave no expected retires for one of the programs");
            errors++;
        end
    endtask

    // Slave model that decides what the DUT sees at the coming rising edge
    task automatic serve_bus();
        logic [31:0] widx;
        if (!rst_n) dp_pending = 1'b0;
        if (dp_pending && !in_program(dp_addr)) s_hready = 1'b0;  // Stall past program end
        else s_hready = ($random(seed) & 3) != 0;
        s_hresp      = 1'b0;
        s_hrdata     = '0;
        s_hrchecksum = '0;
        if (dp_pending && s_hready) begin
            widx         = dp_addr >> 2;
            s_hrdata     = mem_word[widx];
            s_hrchecksum = mem_chk[widx];
            if (mem_fault[widx] != 0) begin
                if (hresp_run) s_hresp = 1'b1;
                else s_hrchecksum = mem_chk[widx] ^ 7'd1;
            end
        end
        if (rst_n && s_hready) begin
            dp_pending = (s_htrans == ahb_pkg::NONSEQ);
            if (dp_pending) begin
                check_val("s_i_haddr_o", s_haddr, next_addr);
                dp_addr   = s_haddr;
                next_addr = next_addr + 32'd4;
            end
        end
    endtask

    task automatic watch_outputs();
        if (!rst_n) begin
            check_val("s_i_htrans_o", s_htrans, ahb_pkg::IDLE);
            check_val("s_ret_valid_o", s_ret_valid, 1'b0);
            check_val("s_fetch_err_o", s_fetch_err, 1'b0);
        end else begin
            if (s_ret_valid) begin
                if (ret_idx < exp_cnt[prog]) begin
                    check_val("s_ret_rd_o", s_ret_rd, exp_rd[prog][ret_idx]);
                    check_val("s_ret_val_o", s_ret_val, exp_val[prog][ret_idx]);
                end else begin
                    $display("Unexpected extra retire in program %0d at %0t", prog, $time);
                    errors++;
                end
                ret_idx++;
            end
            if (s_fetch_err) err_seen = 1'b1;
            if (err_seen) begin                       // Halted for good
                check_val("s_fetch_err_o", s_fetch_err, 1'b1);
                check_val("s_i_htrans_o", s_htrans, ahb_pkg::IDLE);
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge s_clk);
        watch_outputs();
        serve_bus();
    endtask

    task automatic run_program(input int p, input bit fault_run, input bit use_hresp);
        prog       = p;
        hresp_run  = use_hresp;
        base_word  = boot_addr(p) >> 2;
        end_word   = base_word + word_cnt[p];
        next_addr  = boot_addr(p);
        ret_idx    = 0;
        err_seen   = 1'b0;
        s_boot_add = boot_addr(p);
        rst_n      = 1'b0;
        repeat (2) step_cycle();
        rst_n = 1'b1;
        if (fault_run) begin
            while (!err_seen) step_cycle();
        end else begin
            while (ret_idx < exp_cnt[p]) step_cycle();
        end
        repeat (DRAIN) step_cycle();
        check_val("retire count", ret_idx, exp_cnt[p]);
        check_val("s_fetch_err_o", s_fetch_err, fault_run);
    endtask

    initial begin
        seed         = 32'h1bec_521f;
        errors       = 0;
        rst_n        = 1'b0;
        s_boot_add   = '0;
        s_hready     = 1'b1;
        s_hresp      = 1'b0;
        s_hrdata     = '0;
        s_hrchecksum = '0;
        load_vectors();
        loaded = 1'b1;
        run_program(0, 1'b0, 1'b0);                   // Clean program A
        run_program(1, 1'b1, 1'b0);                   // Program B with a bad checksum
        run_program(1, 1'b1, 1'b1);                   // Program B with an error response
        $display("Checks done, check errors: %0d, assertion failures: %0d", errors,
                 core_top_inst.m_core_assertions.fail_cnt);
        errors += core_top_inst.m_core_assertions.fail_cnt;
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((40 * (word_cnt[0] + 2 * word_cnt[1]) + 200) * CLK_PERIOD);
        $display("Watchdog expired, the DUT stopped making progress");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: verif/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
    input logic             s_clk_i,
    input logic             rst_n_i,
    input logic             s_i_hready_i,
    input ahb_pkg::htrans_e s_i_htrans_o,
    input isa_pkg::word_t   s_i_haddr_o,
    input logic             s_fetch_err_o,
    input logic             s_ret_valid_o
);

    int fail_cnt = 0;                                   // Failed assertions so far

    // Address phase is held through bus wait states
    a_addr_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        (!s_i_hready_i && (s_i_htrans_o == ahb_pkg::NONSEQ))
        |=> ($stable(s_i_htrans_o) && $stable(s_i_haddr_o)))
        else begin
            $error("htrans or haddr changed during a wait state");
            fail_cnt++;
        end

    a_err_sticky: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        s_fetch_err_o |=> s_fetch_err_o)                // Only reset clears it
        else begin
            $error("fetch error flag fell without reset");
            fail_cnt++;
        end

    // Fetch needs at least two edges before anything can retire
    a_no_early_retire: assert property (@(posedge s_clk_i)
        $rose(rst_n_i) |-> !s_ret_valid_o [*2])
        else begin
            $error("retire seen right after reset");
            fail_cnt++;
        end

endmodule

bind core_top core_assertions m_core_assertions (
    .s_clk_i       (s_clk_i),
    .rst_n_i       (rst_n_i),
    .s_i_hready_i  (s_i_hready_i),
    .s_i_htrans_o  (s_i_htrans_o),
    .s_i_haddr_o   (s_i_haddr_o),
    .s_fetch_err_o (s_fetch_err_o),
    .s_ret_valid_o (s_ret_valid_o)
);

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4                        // Full clock period
) (
    output logic s_clk_o
);

    initial begin
        s_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) s_clk_o = ~s_clk_o;
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic             s_clk_i,          // Core clock
    input  logic             rst_n_i,          // Synchronous reset, active low
    input  isa_pkg::word_t   s_boot_add_i,     // First fetch address
    input  isa_pkg::word_t   s_i_hrdata_i,     // Instruction bus read data
    input  logic             s_i_hready_i,
    input  logic             s_i_hresp_i,
    input  ahb_pkg::chk_t    s_i_hrchecksum_i, // Checksum of read data
    output isa_pkg::word_t   s_i_haddr_o,
    output ahb_pkg::htrans_e s_i_htrans_o,
    output logic             s_fetch_err_o,    // Fetch halted on a fault
    output logic             s_ret_valid_o,
    output isa_pkg::rf_add_t s_ret_rd_o,
    output isa_pkg::word_t   s_ret_val_o
);

    logic             s_feex_valid;
    isa_pkg::word_t   s_feex_instr;
    isa_pkg::rf_add_t s_rs1;
    isa_pkg::rf_add_t s_rs2;
    logic             s_wb_we;
    isa_pkg::rf_add_t s_wb_rd;
    isa_pkg::word_t   s_wb_val;
    isa_pkg::word_t   s_p1_val;
    isa_pkg::word_t   s_p2_val;

    pipeline_1_fe m_pipe_1_fe (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .s_boot_add_i   (s_boot_add_i),
        .s_hrdata_i     (s_i_hrdata_i),
        .s_hready_i     (s_i_hready_i),
        .s_hresp_i      (s_i_hresp_i),
        .s_hrdcheck_i   (s_i_hrchecksum_i),
        .s_haddr_o      (s_i_haddr_o),
        .s_htrans_o     (s_i_htrans_o),
        .s_feex_valid_o (s_feex_valid),
        .s_feex_instr_o (s_feex_instr),
        .s_fetch_err_o  (s_fetch_err_o)
    );

    pipeline_2_ex m_pipe_2_ex (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .s_feex_valid_i (s_feex_valid),
        .s_feex_instr_i (s_feex_instr),
        .s_p1_val_i     (s_p1_val),
        .s_p2_val_i     (s_p2_val),
        .s_rs1_o        (s_rs1),
        .s_rs2_o        (s_rs2),
        .s_wb_we_o      (s_wb_we),
        .s_wb_rd_o      (s_wb_rd),
        .s_wb_val_o     (s_wb_val),
        .s_ret_valid_o  (s_ret_valid_o),
        .s_ret_rd_o     (s_ret_rd_o),
        .s_ret_val_o    (s_ret_val_o)
    );

    rf_controller m_rfc (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .s_we_i         (s_wb_we),
        .s_wr_add_i     (s_wb_rd),
        .s_wr_val_i     (s_wb_val),
        .s_r_p1_add_i   (s_rs1),
        .s_r_p2_add_i   (s_rs2),
        .s_p1_val_o     (s_p1_val),
        .s_p2_val_o     (s_p2_val)
    );

endmodule

// File: src/rf_controller.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module rf_controller (
    input  logic             s_clk_i,          // Core clock
    input  logic             rst_n_i,          // Synchronous reset, active low
    input  logic             s_we_i,           // Write enable
    input  isa_pkg::rf_add_t s_wr_add_i,
    input  isa_pkg::word_t   s_wr_val_i,
    input  isa_pkg::rf_add_t s_r_p1_add_i,     // Read port 1 address
    input  isa_pkg::rf_add_t s_r_p2_add_i,     // Read port 2 address
    output isa_pkg::word_t   s_p1_val_o,
    output isa_pkg::word_t   s_p2_val_o
);

    isa_pkg::word_t s_regs [`RF_REGS];

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RF_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (s_we_i && (s_wr_add_i != '0)) begin
            s_regs[s_wr_add_i] <= s_wr_val_i;
        end
    end

    // x0 is hard-wired to zero
    assign s_p1_val_o = (s_r_p1_add_i == '0) ? '0 : s_regs[s_r_p1_add_i];
    assign s_p2_val_o = (s_r_p2_add_i == '0) ? '0 : s_regs[s_r_p2_add_i];

endmodule

// File: src/pipeline_2_ex.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pipeline_2_ex (
    input  logic             s_clk_i,          // Core clock
    input  logic             rst_n_i,          // Synchronous reset, active low
    input  logic             s_feex_valid_i,   // Instruction from fetch is valid
    input  isa_pkg::word_t   s_feex_instr_i,
    input  isa_pkg::word_t   s_p1_val_i,       // Value of rs1
    input  isa_pkg::word_t   s_p2_val_i,       // Value of rs2
    output isa_pkg::rf_add_t s_rs1_o,
    output isa_pkg::rf_add_t s_rs2_o,
    output logic             s_wb_we_o,        // Register write enable
    output isa_pkg::rf_add_t s_wb_rd_o,
    output isa_pkg::word_t   s_wb_val_o,
    output logic             s_ret_valid_o,    // Retire record valid
    output isa_pkg::rf_add_t s_ret_rd_o,
    output isa_pkg::word_t   s_ret_val_o
);

    isa_pkg::opcode_e s_opcode;
    isa_pkg::funct3_e s_funct3;
    isa_pkg::alu_op_e s_alu_op;
    isa_pkg::rf_add_t s_rd;
    isa_pkg::rf_add_t s_ret_rd;
    isa_pkg::word_t   s_imm_i;
    isa_pkg::word_t   s_imm_u;
    isa_pkg::word_t   s_op2;
    isa_pkg::word_t   s_result;
    isa_pkg::word_t   s_ret_val;
    logic [6:0]       s_funct7;
    logic             s_legal;
    logic             s_we;
    logic             s_ret_valid;

    assign s_opcode = isa_pkg::opcode_e'(s_feex_instr_i[6:0]);
    assign s_funct3 = isa_pkg::funct3_e'(s_feex_instr_i[14:12]);
    assign s_funct7 = s_feex_instr_i[31:25];
    assign s_rd     = s_feex_instr_i[11:7];
    assign s_rs1_o  = s_feex_instr_i[19:15];
    assign s_rs2_o  = s_feex_instr_i[24:20];
    assign s_imm_i  = {{(`XLEN-12){s_feex_instr_i[31]}}, s_feex_instr_i[31:20]};
    assign s_imm_u  = {s_feex_instr_i[31:12], 12'b0};

    always_comb begin
        s_legal  = 1'b1;
        s_alu_op = isa_pkg::PASS;
        s_op2    = s_imm_i;
        case (s_funct3)
            isa_pkg::F3_ADD: begin
                s_alu_op = (s_opcode == isa_pkg::OP_REG && s_funct7[5]) ? isa_pkg::SUB
                                                                        : isa_pkg::ADD;
            end
            isa_pkg::F3_XOR: s_alu_op = isa_pkg::XOR;
            isa_pkg::F3_OR:  s_alu_op = isa_pkg::OR;
            isa_pkg::F3_AND: s_alu_op = isa_pkg::AND;
            default:         s_legal  = 1'b0;
        endcase
        case (s_opcode)
            isa_pkg::OP_IMM: s_op2 = s_imm_i;
            isa_pkg::OP_REG: begin
                s_op2 = s_p2_val_i;
                if ((s_funct7 != 7'b0) &&
                    !((s_funct7 == 7'b0100000) && (s_funct3 == isa_pkg::F3_ADD))) begin
                    s_legal = 1'b0;                    // Unsupported funct7
                end
            end
            isa_pkg::OP_LUI: begin
                s_op2    = s_imm_u;
                s_alu_op = isa_pkg::PASS;
                s_legal  = 1'b1;                       // funct3 bits belong to the immediate
            end
            default:         s_legal = 1'b0;
        endcase
    end

    always_comb begin
        case (s_alu_op)
            isa_pkg::ADD: s_result = s_p1_val_i + s_op2;
            isa_pkg::SUB: s_result = s_p1_val_i - s_op2;
            isa_pkg::XOR: s_result = s_p1_val_i ^ s_op2;
            isa_pkg::OR:  s_result = s_p1_val_i | s_op2;
            isa_pkg::AND: s_result = s_p1_val_i & s_op2;
            default:      s_result = s_op2;
        endcase
    end

    // Writes to x0 and no-ops leave the register file alone
    assign s_we       = s_feex_valid_i && s_legal && (s_rd != '0);
    assign s_wb_we_o  = s_we;
    assign s_wb_rd_o  = s_rd;
    assign s_wb_val_o = s_result;

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            s_ret_valid <= 1'b0;
        end else begin
            s_ret_valid <= s_feex_valid_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        s_ret_rd  <= s_we ? s_rd : '0;
        s_ret_val <= s_we ? s_result : '0;
    end

    assign s_ret_valid_o = s_ret_valid;
    assign s_ret_rd_o    = s_ret_rd;
    assign s_ret_val_o   = s_ret_val;

endmodule

// File: src/pipeline_1_fe.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pipeline_1_fe (
    input  logic             s_clk_i,          // Core clock
    input  logic             rst_n_i,          // Synchronous reset, active low
    input  isa_pkg::word_t   s_boot_add_i,     // First fetch address
    input  isa_pkg::word_t   s_hrdata_i,       // AHB read data
    input  logic             s_hready_i,       // AHB transfer done
    input  logic             s_hresp_i,        // AHB error response
    input  ahb_pkg::chk_t    s_hrdcheck_i,     // Checksum sent along with hrdata
    output isa_pkg::word_t   s_haddr_o,        // AHB address
    output ahb_pkg::htrans_e s_htrans_o,       // AHB transfer type
    output logic             s_feex_valid_o,   // Instruction for execute is valid
    output isa_pkg::word_t   s_feex_instr_o,   // Instruction for execute
    output logic             s_fetch_err_o     // Sticky fetch fault
);

    ahb_pkg::fe_state_e s_state;
    ahb_pkg::htrans_e   s_htrans;
    ahb_pkg::chk_t      s_calc_chk;
    isa_pkg::word_t     s_haddr;
    isa_pkg::word_t     s_instr;
    logic               s_dp_pending;
    logic               s_valid;
    logic               s_ap_accept;
    logic               s_dp_done;
    logic               s_dp_fault;

    // Bit k covers data bits whose index has bit k set and the top bit is overall parity
    function automatic ahb_pkg::chk_t f_checksum(input isa_pkg::word_t data);
        ahb_pkg::chk_t chk;
        chk = '0;
        for (int k = 0; k < `CHK_W - 1; k++) begin
            for (int i = 0; i < `XLEN; i++) begin
                if (i[k]) begin
                    chk[k] = chk[k] ^ data[i];
                end
            end
        end
        chk[`CHK_W-1] = ^data;
        return chk;
    endfunction

    assign s_calc_chk  = f_checksum(s_hrdata_i);
    assign s_ap_accept = (s_htrans == ahb_pkg::NONSEQ) && s_hready_i;
    assign s_dp_done   = s_dp_pending && s_hready_i;
    assign s_dp_fault  = s_dp_done && (s_hresp_i || (s_calc_chk != s_hrdcheck_i));

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            s_state      <= ahb_pkg::RUN;
            s_htrans     <= ahb_pkg::IDLE;
            s_haddr      <= s_boot_add_i;
            s_dp_pending <= 1'b0;
            s_valid      <= 1'b0;
        end else if (s_state == ahb_pkg::RUN) begin
            if (s_dp_fault) begin
                s_state      <= ahb_pkg::HALT;         // Stop for good
                s_htrans     <= ahb_pkg::IDLE;
                s_dp_pending <= 1'b0;                  // Drop the pending address phase
                s_valid      <= 1'b0;
            end else begin
                s_htrans <= ahb_pkg::NONSEQ;
                s_valid  <= s_dp_done;
                if (s_ap_accept) begin
                    s_haddr      <= s_haddr + 32'd4;
                    s_dp_pending <= 1'b1;              // Data phase follows
                end else if (s_dp_done) begin
                    s_dp_pending <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (s_dp_done && !s_dp_fault) begin
            s_instr <= s_hrdata_i;
        end
    end

    assign s_haddr_o      = s_haddr;
    assign s_htrans_o     = s_htrans;
    assign s_feex_valid_o = s_valid;
    assign s_feex_instr_o = s_instr;
    assign s_fetch_err_o  = (s_state == ahb_pkg::HALT);

endmodule

// File: src/ahb_pkg.sv
`include "core_macros.svh"

package ahb_pkg;

    // Only the transfer types the fetch master issues
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef logic [`CHK_W-1:0] chk_t;                  // Checksum carried with hrdata

    // Fetch control where HALT is left only by reset
    typedef enum logic {
        RUN,
        HALT
    } fe_state_e;

endpackage

// File: src/isa_pkg.sv
`include "core_macros.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] word_t;                  // Data or instruction word
    typedef logic [$clog2(`RF_REGS)-1:0] rf_add_t;     // Register index

    // Major opcodes handled by execute
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,                           // Register-immediate ALU
        OP_REG = 7'b0110011,                           // Register-register ALU
        OP_LUI = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD = 3'b000,                               // Shared by ADD, SUB and ADDI
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        PASS                                           // Second operand straight through
    } alu_op_e;

endpackage

// File: include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Core data path width
`define XLEN 32

// Number of integer registers including x0
`define RF_REGS 32

// Width of the custom read-data checksum
`define CHK_W 7

`endif
